//--- design/rv_pkg.sv
/*
 * Shared types and constants for the four-stage RV32I core.
 * Word accesses only, and the memory map assumes 32-bit aligned addresses.
 */
`default_nettype none

package rv_pkg;

	// Datapath and memory sizes
	localparam int XLEN      = 32;
	localparam int RAM_WORDS = 128;
	localparam int ROM_WORDS = 64;
	localparam int RAM_AW    = $clog2(RAM_WORDS);
	localparam int ROM_AW    = $clog2(ROM_WORDS);

	// Memory map
	localparam logic [XLEN-1:0] RAM_BASE       = 32'h1001_0000;
	localparam logic [XLEN-1:0] UART_DATA_ADDR = 32'h1001_0400;
	localparam logic [XLEN-1:0] UART_STAT_ADDR = 32'h1001_0404;

	// UART bit length in clocks
	localparam int CLKS_PER_BIT = 4;
	localparam int BAUD_CW      = $clog2(CLKS_PER_BIT);

	// addi x0, x0, 0
	localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

	// Major opcodes
	localparam logic [6:0] OP_R      = 7'b0110011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
	} alu_op_t;

	// Writeback source, same order as the four-input mux
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4, WB_IMM} wb_sel_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] instr;
	} if_id_t;

	typedef struct packed {
		logic    alu_src_a; // 1 selects pc
		logic    alu_src_b; // 1 selects imm
		alu_op_t alu_op;
		logic    branch;
		logic    bne;
		logic    jump;
		logic    jalr;
		logic    mem_read;
		logic    mem_write;
		logic    reg_write;
		wb_sel_t wb_sel;
	} ctrl_t;

	localparam ctrl_t CTRL_NOP = '{alu_src_a: 1'b0, alu_src_b: 1'b0, alu_op: ALU_PASS_B,
		branch: 1'b0, bne: 1'b0, jump: 1'b0, jalr: 1'b0, mem_read: 1'b0,
		mem_write: 1'b0, reg_write: 1'b0, wb_sel: WB_ALU};

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] rs1_val;
		logic [XLEN-1:0] rs2_val;
		logic [XLEN-1:0] imm;
		logic [4:0]      rd;
		ctrl_t           ctrl;
	} id_ex_t;

	typedef struct packed {
		logic [XLEN-1:0] alu_result;
		logic [XLEN-1:0] store_data;
		logic [XLEN-1:0] pc_plus_4;
		logic [XLEN-1:0] imm;
		logic [4:0]      rd;
		logic            mem_read;
		logic            mem_write;
		logic            reg_write;
		wb_sel_t         wb_sel;
	} ex_mem_t;

	// Wishbone master request and slave response
	typedef struct packed {
		logic            cyc;
		logic            stb;
		logic            we;
		logic [XLEN-1:0] adr;
		logic [XLEN-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic            ack;
		logic [XLEN-1:0] dat;
	} wb_rsp_t;

	typedef struct packed {
		logic            en;
		logic [4:0]      rd;
		logic [XLEN-1:0] data;
	} reg_wr_t;

endpackage

`default_nettype wire

//--- design/rv_fetch.sv
/*
 * Fetch stage. The ROM loads program.hex at elaboration and is read combinationally.
 * A stall overrides a redirect; execute holds the redirect until the stall ends.
 */
`default_nettype none

module rv_fetch (
	input  wire                     i_clk,
	input  wire                     i_reset,
	input  wire                     i_stall,
	input  wire                     i_redirect,
	input  wire  [rv_pkg::XLEN-1:0] i_target,
	output rv_pkg::if_id_t          o_if_id
);

	logic [rv_pkg::XLEN-1:0] pc;
	logic [rv_pkg::XLEN-1:0] rom [rv_pkg::ROM_WORDS];
	logic [rv_pkg::XLEN-1:0] instr;

	initial begin
		$readmemh("program.hex", rom);
	end

	// Word index from the pc
	assign instr = rom[pc[rv_pkg::ROM_AW+1:2]];

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			pc            <= '0;
			o_if_id.pc    <= '0;
			o_if_id.instr <= rv_pkg::NOP_INSTR;
		end else if (!i_stall) begin
			o_if_id.pc <= pc;
			if (i_redirect) begin
				// Wrong-path fetch becomes a bubble
				pc            <= i_target;
				o_if_id.instr <= rv_pkg::NOP_INSTR;
			end else begin
				pc            <= pc + 32'd4;
				o_if_id.instr <= instr;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/rv_decode.sv
/*
 * Decode stage with the register file. Writes land before reads in the same cycle.
 * No hazard detection; unsupported opcodes and funct codes decode as a NOP.
 */
`default_nettype none

module rv_decode (
	input  wire                     i_clk,
	input  wire                     i_reset,
	input  wire                     i_stall,
	input  wire                     i_flush,
	input  wire  rv_pkg::if_id_t    i_if_id,
	input  wire  rv_pkg::reg_wr_t   i_reg_wr,
	output rv_pkg::id_ex_t          o_id_ex
);

	logic [rv_pkg::XLEN-1:0] regs [32];
	logic [rv_pkg::XLEN-1:0] ins;
	logic [rv_pkg::XLEN-1:0] imm;
	logic [rv_pkg::XLEN-1:0] rs1_val;
	logic [rv_pkg::XLEN-1:0] rs2_val;
	logic [6:0]              opcode;
	logic [2:0]              funct3;
	logic [4:0]              rs1;
	logic [4:0]              rs2;
	rv_pkg::ctrl_t           ctrl;

	assign ins    = i_if_id.instr;
	assign opcode = ins[6:0];
	assign funct3 = ins[14:12];
	assign rs1    = ins[19:15];
	assign rs2    = ins[24:20];

	// Register file, x0 never written
	always_ff @(posedge i_clk) begin
		if (i_reg_wr.en && i_reg_wr.rd != 5'd0)
			regs[i_reg_wr.rd] <= i_reg_wr.data;
	end

	// Read with write-first bypass
	always_comb begin
		if (rs1 == 5'd0)
			rs1_val = '0;
		else if (i_reg_wr.en && i_reg_wr.rd == rs1)
			rs1_val = i_reg_wr.data;
		else
			rs1_val = regs[rs1];
		if (rs2 == 5'd0)
			rs2_val = '0;
		else if (i_reg_wr.en && i_reg_wr.rd == rs2)
			rs2_val = i_reg_wr.data;
		else
			rs2_val = regs[rs2];
	end

	// Immediate by format
	always_comb begin
		case (opcode)
			rv_pkg::OP_STORE:  imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			rv_pkg::OP_BRANCH: imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			rv_pkg::OP_LUI:    imm = {ins[31:12], 12'b0};
			rv_pkg::OP_JAL:    imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			default:           imm = {{20{ins[31]}}, ins[31:20]};
		endcase
	end

	// Control decode
	always_comb begin
		ctrl = rv_pkg::CTRL_NOP;
		case (opcode)
			rv_pkg::OP_R: begin
				ctrl.reg_write = 1'b1;
				case (funct3)
					3'b000:  ctrl.alu_op = ins[30] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
					3'b111:  ctrl.alu_op = rv_pkg::ALU_AND;
					3'b110:  ctrl.alu_op = rv_pkg::ALU_OR;
					3'b100:  ctrl.alu_op = rv_pkg::ALU_XOR;
					3'b010:  ctrl.alu_op = rv_pkg::ALU_SLT;
					default: ctrl = rv_pkg::CTRL_NOP;
				endcase
			end
			rv_pkg::OP_IMM: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_b = 1'b1;
				case (funct3)
					3'b000:  ctrl.alu_op = rv_pkg::ALU_ADD;
					3'b111:  ctrl.alu_op = rv_pkg::ALU_AND;
					3'b110:  ctrl.alu_op = rv_pkg::ALU_OR;
					default: ctrl = rv_pkg::CTRL_NOP;
				endcase
			end
			rv_pkg::OP_LUI: begin
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = rv_pkg::WB_IMM;
			end
			rv_pkg::OP_LOAD: begin
				if (funct3 == 3'b010) begin
					ctrl.alu_src_b = 1'b1;
					ctrl.alu_op    = rv_pkg::ALU_ADD;
					ctrl.mem_read  = 1'b1;
					ctrl.reg_write = 1'b1;
					ctrl.wb_sel    = rv_pkg::WB_MEM;
				end
			end
			rv_pkg::OP_STORE: begin
				if (funct3 == 3'b010) begin
					ctrl.alu_src_b = 1'b1;
					ctrl.alu_op    = rv_pkg::ALU_ADD;
					ctrl.mem_write = 1'b1;
				end
			end
			rv_pkg::OP_BRANCH: begin
				// Compare by subtraction, beq and bne only
				if (funct3[2:1] == 2'b00) begin
					ctrl.alu_op = rv_pkg::ALU_SUB;
					ctrl.branch = 1'b1;
					ctrl.bne    = funct3[0];
				end
			end
			rv_pkg::OP_JAL: begin
				ctrl.alu_src_a = 1'b1;
				ctrl.alu_src_b = 1'b1;
				ctrl.alu_op    = rv_pkg::ALU_ADD;
				ctrl.jump      = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = rv_pkg::WB_PC4;
			end
			rv_pkg::OP_JALR: begin
				ctrl.alu_src_b = 1'b1;
				ctrl.alu_op    = rv_pkg::ALU_ADD;
				ctrl.jump      = 1'b1;
				ctrl.jalr      = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = rv_pkg::WB_PC4;
			end
			default: ctrl = rv_pkg::CTRL_NOP;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_id_ex.ctrl <= rv_pkg::CTRL_NOP;
		end else if (!i_stall) begin
			o_id_ex.pc      <= i_if_id.pc;
			o_id_ex.rs1_val <= rs1_val;
			o_id_ex.rs2_val <= rs2_val;
			o_id_ex.imm     <= imm;
			o_id_ex.rd      <= ins[11:7];
			// Squash when a taken branch sits in execute
			o_id_ex.ctrl    <= i_flush ? rv_pkg::CTRL_NOP : ctrl;
		end
	end

endmodule

`default_nettype wire

//--- design/rv_execute.sv
/*
 * Execute stage. Branches and jumps resolve here and flush the two younger slots.
 * Redirect and flush are combinational from the decode-to-execute register.
 */
`default_nettype none

module rv_execute (
	input  wire                     i_clk,
	input  wire                     i_reset,
	input  wire                     i_stall,
	input  wire  rv_pkg::id_ex_t    i_id_ex,
	output rv_pkg::ex_mem_t         o_ex_mem,
	output logic                    o_redirect,
	output logic [rv_pkg::XLEN-1:0] o_target,
	output logic                    o_flush
);

	logic [rv_pkg::XLEN-1:0] src_a;
	logic [rv_pkg::XLEN-1:0] src_b;
	logic [rv_pkg::XLEN-1:0] alu_result;
	logic                    zero;
	logic                    cond;
	logic                    taken;
	rv_pkg::ctrl_t           ctrl;
	rv_pkg::ex_mem_t         ex_mem_d;

	assign ctrl  = i_id_ex.ctrl;
	assign src_a = ctrl.alu_src_a ? i_id_ex.pc : i_id_ex.rs1_val;
	assign src_b = ctrl.alu_src_b ? i_id_ex.imm : i_id_ex.rs2_val;

	// ALU
	always_comb begin
		case (ctrl.alu_op)
			rv_pkg::ALU_ADD: alu_result = src_a + src_b;
			rv_pkg::ALU_SUB: alu_result = src_a - src_b;
			rv_pkg::ALU_AND: alu_result = src_a & src_b;
			rv_pkg::ALU_OR:  alu_result = src_a | src_b;
			rv_pkg::ALU_XOR: alu_result = src_a ^ src_b;
			rv_pkg::ALU_SLT: alu_result = {31'b0, $signed(src_a) < $signed(src_b)};
			default:         alu_result = src_b;
		endcase
	end

	// Zero or not-zero picks beq versus bne
	assign zero  = (alu_result == '0);
	assign cond  = ctrl.bne ? !zero : zero;
	assign taken = ctrl.jump | (ctrl.branch & cond);

	// jalr clears bit 0 of rs1 plus imm
	assign o_target   = ctrl.jalr ? {alu_result[31:1], 1'b0} : i_id_ex.pc + i_id_ex.imm;
	assign o_redirect = taken;
	assign o_flush    = taken;

	always_comb begin
		ex_mem_d.alu_result = alu_result;
		ex_mem_d.store_data = i_id_ex.rs2_val;
		ex_mem_d.pc_plus_4  = i_id_ex.pc + 32'd4;
		ex_mem_d.imm        = i_id_ex.imm;
		ex_mem_d.rd         = i_id_ex.rd;
		ex_mem_d.mem_read   = ctrl.mem_read;
		ex_mem_d.mem_write  = ctrl.mem_write;
		ex_mem_d.reg_write  = ctrl.reg_write;
		ex_mem_d.wb_sel     = ctrl.wb_sel;
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_ex_mem.mem_read  <= 1'b0;
			o_ex_mem.mem_write <= 1'b0;
			o_ex_mem.reg_write <= 1'b0;
		end else if (!i_stall) begin
			o_ex_mem <= ex_mem_d;
		end
	end

endmodule

`default_nettype wire

//--- design/rv_mem_stage.sv
/*
 * Memory and writeback stage. Wishbone classic master, one access at a time.
 * The pipeline stalls from the start of an access until the cycle of its ack.
 */
`default_nettype none

module rv_mem_stage (
	input  wire                     i_clk,
	input  wire                     i_reset,
	input  wire  rv_pkg::ex_mem_t   i_ex_mem,
	input  wire  rv_pkg::wb_rsp_t   i_wb_rsp,
	output rv_pkg::wb_req_t         o_wb_req,
	output logic                    o_stall,
	output rv_pkg::reg_wr_t         o_reg_wr
);

	typedef enum logic {MS_IDLE, MS_WAIT} ms_state_t;

	ms_state_t state;
	logic      mem_access;
	logic      done;

	assign mem_access = i_ex_mem.mem_read | i_ex_mem.mem_write;
	assign done       = (state == MS_WAIT) && i_wb_rsp.ack;
	assign o_stall    = mem_access && !done;

	// Request is raised from idle and held until ack
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state        <= MS_IDLE;
			o_wb_req.cyc <= 1'b0;
			o_wb_req.stb <= 1'b0;
		end else begin
			case (state)
				MS_IDLE: begin
					if (mem_access) begin
						o_wb_req.cyc <= 1'b1;
						o_wb_req.stb <= 1'b1;
						o_wb_req.we  <= i_ex_mem.mem_write;
						o_wb_req.adr <= i_ex_mem.alu_result;
						o_wb_req.dat <= i_ex_mem.store_data;
						state        <= MS_WAIT;
					end
				end
				MS_WAIT: begin
					// Drop the cycle after ack
					if (i_wb_rsp.ack) begin
						o_wb_req.cyc <= 1'b0;
						o_wb_req.stb <= 1'b0;
						state        <= MS_IDLE;
					end
				end
				default: state <= MS_IDLE;
			endcase
		end
	end

	// Writeback once, in the last cycle of the instruction
	always_comb begin
		o_reg_wr.en = i_ex_mem.reg_write && !o_stall;
		o_reg_wr.rd = i_ex_mem.rd;
		case (i_ex_mem.wb_sel)
			rv_pkg::WB_MEM: o_reg_wr.data = i_wb_rsp.dat;
			rv_pkg::WB_PC4: o_reg_wr.data = i_ex_mem.pc_plus_4;
			rv_pkg::WB_IMM: o_reg_wr.data = i_ex_mem.imm;
			default:        o_reg_wr.data = i_ex_mem.alu_result;
		endcase
	end

endmodule

`default_nettype wire

//--- design/rv_data_bus.sv
/*
 * Data bus with address decode, the word RAM and response routing.
 * RAM and unmapped addresses ack one cycle after stb; unmapped reads return zero.
 */
`default_nettype none

module rv_data_bus (
	input  wire                     i_clk,
	input  wire                     i_reset,
	input  wire  rv_pkg::wb_req_t   i_wb_req,
	input  wire  rv_pkg::wb_rsp_t   i_uart_rsp,
	output rv_pkg::wb_rsp_t         o_wb_rsp,
	output rv_pkg::wb_req_t         o_uart_req
);

	logic [rv_pkg::XLEN-1:0]   ram [rv_pkg::RAM_WORDS];
	logic [rv_pkg::XLEN-1:0]   ram_off;
	logic [rv_pkg::XLEN-1:0]   ram_q;
	logic [rv_pkg::RAM_AW-1:0] ram_idx;
	logic                      sel_ram;
	logic                      sel_uart;
	logic                      req;
	logic                      local_ack;

	// Address decode
	assign ram_off  = i_wb_req.adr - rv_pkg::RAM_BASE;
	assign sel_ram  = ram_off < rv_pkg::XLEN'(rv_pkg::RAM_WORDS * 4);
	assign sel_uart = i_wb_req.adr[31:3] == rv_pkg::UART_DATA_ADDR[31:3];
	assign ram_idx  = ram_off[rv_pkg::RAM_AW+1:2];

	// Request seen by RAM or the unmapped responder
	assign req = i_wb_req.cyc && i_wb_req.stb && !sel_uart;

	// Only the UART sees its own strobe
	always_comb begin
		o_uart_req     = i_wb_req;
		o_uart_req.cyc = i_wb_req.cyc && sel_uart;
		o_uart_req.stb = i_wb_req.stb && sel_uart;
	end

	// One ack per request
	always_ff @(posedge i_clk) begin
		if (i_reset)
			local_ack <= 1'b0;
		else
			local_ack <= req && !local_ack;
	end

	// Word RAM, write in the first cycle of the request
	always_ff @(posedge i_clk) begin
		if (req && sel_ram && i_wb_req.we && !local_ack)
			ram[ram_idx] <= i_wb_req.dat;
		ram_q <= ram[ram_idx];
	end

	always_comb begin
		o_wb_rsp.ack = local_ack | i_uart_rsp.ack;
		if (i_uart_rsp.ack)
			o_wb_rsp.dat = i_uart_rsp.dat;
		else if (sel_ram)
			o_wb_rsp.dat = ram_q;
		else
			o_wb_rsp.dat = '0;
	end

endmodule

`default_nettype wire

//--- design/rv_uart_tx.sv
/*
 * Transmit-only UART, 8N1, LSB first. Status bit 0 reads busy.
 * A data write while busy is acked and dropped, so software polls first.
 */
`default_nettype none

module rv_uart_tx (
	input  wire                     i_clk,
	input  wire                     i_reset,
	input  wire  rv_pkg::wb_req_t   i_wb_req,
	output rv_pkg::wb_rsp_t         o_wb_rsp,
	output logic                    o_tx
);

	logic [9:0]                 shifter;
	logic [3:0]                 bits_left;
	logic [rv_pkg::BAUD_CW-1:0] baud_cnt;
	logic                       busy;
	logic                       ack_q;
	logic                       load;
	logic                       bit_end;

	assign load    = i_wb_req.cyc && i_wb_req.stb && i_wb_req.we && !ack_q && !busy
		&& i_wb_req.adr == rv_pkg::UART_DATA_ADDR;
	assign bit_end = baud_cnt == rv_pkg::BAUD_CW'(rv_pkg::CLKS_PER_BIT - 1);

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			ack_q     <= 1'b0;
			busy      <= 1'b0;
			baud_cnt  <= '0;
			bits_left <= '0;
		end else begin
			ack_q <= i_wb_req.cyc && i_wb_req.stb && !ack_q;
			if (load) begin
				// Stop, data, start
				shifter   <= {1'b1, i_wb_req.dat[7:0], 1'b0};
				bits_left <= 4'd10;
				baud_cnt  <= '0;
				busy      <= 1'b1;
			end else if (busy) begin
				baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
				if (bit_end) begin
					shifter   <= {1'b1, shifter[9:1]};
					bits_left <= bits_left - 4'd1;
					// Stop bit finished
					if (bits_left == 4'd1)
						busy <= 1'b0;
				end
			end
		end
	end

	// Idle line high
	assign o_tx = busy ? shifter[0] : 1'b1;

	assign o_wb_rsp.ack = ack_q;
	assign o_wb_rsp.dat = (i_wb_req.adr == rv_pkg::UART_STAT_ADDR) ?
		{{(rv_pkg::XLEN-1){1'b0}}, busy} : '0;

endmodule

`default_nettype wire

//--- design/risc_v_top.sv
/*
 * Four-stage RV32I core with RAM and a transmit-only UART on a Wishbone bus.
 * Software must separate dependent instructions by two slots.
 */
`default_nettype none

module risc_v_top (
	input  wire  i_clk,
	input  wire  i_reset,
	output logic o_tx
);

	// Stage registers
	rv_pkg::if_id_t          if_id;
	rv_pkg::id_ex_t          id_ex;
	rv_pkg::ex_mem_t         ex_mem;
	// Pipeline control and writeback
	rv_pkg::reg_wr_t         reg_wr;
	logic                    stall;
	logic                    redirect;
	logic                    flush;
	logic [rv_pkg::XLEN-1:0] target;
	// Bus
	rv_pkg::wb_req_t         wb_req;
	rv_pkg::wb_rsp_t         wb_rsp;
	rv_pkg::wb_req_t         uart_req;
	rv_pkg::wb_rsp_t         uart_rsp;

	// Input side
	rv_fetch u_fetch (
		.i_clk(i_clk), .i_reset(i_reset), .i_stall(stall),
		.i_redirect(redirect), .i_target(target), .o_if_id(if_id)
	);

	// Processing
	rv_decode u_decode (
		.i_clk(i_clk), .i_reset(i_reset), .i_stall(stall), .i_flush(flush),
		.i_if_id(if_id), .i_reg_wr(reg_wr), .o_id_ex(id_ex)
	);

	rv_execute u_execute (
		.i_clk(i_clk), .i_reset(i_reset), .i_stall(stall), .i_id_ex(id_ex),
		.o_ex_mem(ex_mem), .o_redirect(redirect), .o_target(target), .o_flush(flush)
	);

	// Output side
	rv_mem_stage u_mem_stage (
		.i_clk(i_clk), .i_reset(i_reset), .i_ex_mem(ex_mem), .i_wb_rsp(wb_rsp),
		.o_wb_req(wb_req), .o_stall(stall), .o_reg_wr(reg_wr)
	);

	rv_data_bus u_data_bus (
		.i_clk(i_clk), .i_reset(i_reset), .i_wb_req(wb_req), .i_uart_rsp(uart_rsp),
		.o_wb_rsp(wb_rsp), .o_uart_req(uart_req)
	);

	rv_uart_tx u_uart_tx (
		.i_clk(i_clk), .i_reset(i_reset), .i_wb_req(uart_req),
		.o_wb_rsp(uart_rsp), .o_tx(o_tx)
	);

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
/*
 * Free-running testbench clock, 100 ns period, starts low.
 */
`default_nettype none

module tb_clock (
	output logic o_clk
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		o_clk = 1'b0;
		forever #50 o_clk = ~o_clk;
	end

endmodule

`default_nettype wire

//--- dv/risc_v_checker.sv
/*
 * Bus protocol and serial line assertions, bound into the core top level.
 * Bus checks are disabled while reset is high.
 */
`default_nettype none

module risc_v_checker (
	input wire                   i_clk,
	input wire                   i_reset,
	input wire rv_pkg::wb_req_t  i_wb_req,
	input wire rv_pkg::wb_rsp_t  i_wb_rsp,
	input wire                   i_tx
);
	timeunit 1ns;
	timeprecision 100ps;

	// Strobe only inside a cycle
	stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
		i_wb_req.stb |-> i_wb_req.cyc)
		else $error("Wishbone stb high without cyc");

	// Slave never acks an idle bus
	ack_needs_stb: assert property (@(posedge i_clk) disable iff (i_reset)
		i_wb_rsp.ack |-> i_wb_req.stb)
		else $error("Wishbone ack without stb");

	// Master holds the request until ack
	req_held: assert property (@(posedge i_clk) disable iff (i_reset)
		i_wb_req.stb && !i_wb_rsp.ack |=> i_wb_req.stb && $stable(i_wb_req.we)
		&& $stable(i_wb_req.adr) && $stable(i_wb_req.dat))
		else $error("Wishbone request changed before ack");

	// Line idles high once reset has taken effect
	tx_idle_reset: assert property (@(posedge i_clk)
		i_reset && $past(i_reset) |-> i_tx)
		else $error("Serial line low during reset");

endmodule

`default_nettype wire

//--- dv/risc_v_tb.sv
/*
 * Directed testbench for the core. Results come only from the UART line.
 * The ROM image program.hex must be in the working directory of the run.
 */
`default_nettype none

module risc_v_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int     CLK_NS      = 100;
	localparam int     FRAME_CLKS  = 10 * rv_pkg::CLKS_PER_BIT;
	// 80 frames plus room for reset and the polling software
	localparam longint WATCHDOG_NS = 80 * FRAME_CLKS * CLK_NS + 20000;

	typedef logic [7:0] uart_byte_t;

	logic clk;
	logic reset;
	wire  tx;

	tb_clock u_clock (.o_clk(clk));

	risc_v_top UUT (
		.i_clk(clk),
		.i_reset(reset),
		.o_tx(tx)
	);

	bind risc_v_top risc_v_checker u_checker (
		.i_clk(i_clk), .i_reset(i_reset), .i_wb_req(wb_req),
		.i_wb_rsp(wb_rsp), .i_tx(o_tx)
	);

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
		if (act !== exp) begin
			$display("Fail %s: expected 0x%02h, actual 0x%02h", name, exp, act);
			$display("*** TEST FAILED ***");
			$fatal(1, "Byte mismatch");
		end
	endtask

	// 8N1 receiver sampling at bit centres on the falling clock edge
	task automatic recv_byte(output uart_byte_t data);
		@(negedge clk);
		while (tx !== 1'b0)
			@(negedge clk);
		repeat (rv_pkg::CLKS_PER_BIT / 2) @(negedge clk);
		if (tx !== 1'b0)
			fail_now("UART start bit ended before its centre");
		for (int i = 0; i < 8; i++) begin
			repeat (rv_pkg::CLKS_PER_BIT) @(negedge clk);
			data[i] = tx;
		end
		repeat (rv_pkg::CLKS_PER_BIT) @(negedge clk);
		if (tx !== 1'b1)
			fail_now("UART stop bit was low");
	endtask

	task automatic expect_byte(input string name, input uart_byte_t exp);
		uart_byte_t got;
		recv_byte(got);
		check_byte(name, exp, got);
	endtask

	task automatic test_alu();
		uart_byte_t a = 8'd7;
		uart_byte_t b = 8'd5;
		expect_byte("alu_add", a + b);
		expect_byte("alu_sub", a - b);
		expect_byte("alu_and", a & b);
		expect_byte("alu_or", a | b);
		expect_byte("alu_xor", a ^ b);
		expect_byte("alu_slt", uart_byte_t'(b < a));
	endtask

	task automatic test_immediates();
		logic [31:0] upper = 32'h12 << 12;
		expect_byte("lui_addi", uart_byte_t'(upper + 32'h234));
		expect_byte("andi", 8'h3F & 8'h0F);
	endtask

	task automatic test_memory();
		// Loads come back in reverse order of the stores
		expect_byte("load_word1", 8'h5A);
		expect_byte("load_word0", 8'hA5);
		expect_byte("load_unmapped", 8'h00);
	endtask

	task automatic test_branches();
		for (int i = 0; i < 5; i++)
			expect_byte("bne_loop", uart_byte_t'(i));
		// 0xEE is skipped by the beq
		expect_byte("beq_skip", 8'h3C);
	endtask

	task automatic test_back_pressure();
		for (int i = 0; i < 8; i++)
			expect_byte("back_to_back", uart_byte_t'(8'h80 + i));
	endtask

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired before all UART bytes arrived");
		$display("*** TEST FAILED ***");
		$fatal(1, "Timeout");
	end

	initial begin
		reset = 1'b1;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		test_alu();
		test_immediates();
		test_memory();
		test_branches();
		test_back_pressure();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
design/rv_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_mem_stage.sv
design/rv_data_bus.sv
design/rv_uart_tx.sv
design/risc_v_top.sv
dv/tb_clock.sv
dv/risc_v_checker.sv
dv/risc_v_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from dv/, where the ROM image lives.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f filelist.f --top-module risc_v_tb -Mdir obj_dir -o risc_v_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

(cd dv && ../obj_dir/risc_v_sim) > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- dv/program.hex
// One RV32I instruction word per line, word address 0 first
// s0 = UART base, a0 = byte to send, send subroutine at word 54
10010437 // lui  x8, 0x10010
00700493 // addi x9, x0, 7
00500913 // addi x18, x0, 5
40040413 // addi x8, x8, 0x400
01248533 // add  x10, x9, x18
0C4000EF // jal  x1, send
41248533 // sub  x10, x9, x18
0BC000EF // jal  x1, send
0124F533 // and  x10, x9, x18
0B4000EF // jal  x1, send
0124E533 // or   x10, x9, x18
0AC000EF // jal  x1, send
0124C533 // xor  x10, x9, x18
0A4000EF // jal  x1, send
00992533 // slt  x10, x18, x9
09C000EF // jal  x1, send
000125B7 // lui  x11, 0x12
03F06613 // ori  x12, x0, 0x3f
23458513 // addi x10, x11, 0x234
08C000EF // jal  x1, send
00F67513 // andi x10, x12, 0xf
084000EF // jal  x1, send
100109B7 // lui  x19, 0x10010
20000A37 // lui  x20, 0x20000
0A500693 // addi x13, x0, 0xa5
05A00713 // addi x14, x0, 0x5a
00D9A023 // sw   x13, 0(x19)
00E9A223 // sw   x14, 4(x19)
0049A503 // lw   x10, 4(x19)
064000EF // jal  x1, send
0009A503 // lw   x10, 0(x19)
05C000EF // jal  x1, send
000A2503 // lw   x10, 0(x20)
054000EF // jal  x1, send
00000793 // addi x15, x0, 0
00500813 // addi x16, x0, 5
00078513 // loop1: addi x10, x15, 0
044000EF // jal  x1, send
00178793 // addi x15, x15, 1
00000013 // nop
FF0798E3 // bne  x15, x16, loop1
00000663 // beq  x0, x0, skip
0EE00513 // addi x10, x0, 0xee
02C000EF // jal  x1, send
03C00513 // skip: addi x10, x0, 0x3c
024000EF // jal  x1, send
08000793 // addi x15, x0, 0x80
08800813 // addi x16, x0, 0x88
00078513 // loop2: addi x10, x15, 0
014000EF // jal  x1, send
00178793 // addi x15, x15, 1
00000013 // nop
FF0798E3 // bne  x15, x16, loop2
0000006F // halt: jal x0, halt
00442283 // send: lw x5, 4(x8)
00000013 // nop
FE029CE3 // bne  x5, x0, send
00A42023 // sw   x10, 0(x8)
00008067 // jalr x0, 0(x1)
00000013
00000013
00000013
00000013
00000013
